//--- rtl/ooo_defs.svh
// Sizes of the out-of-order slice
// Entry counts are powers of two so that queue pointers wrap on overflow
// PHY_REG_NUM - ARCH_REG_NUM sets the free list depth and must be a power of two
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Register files
`define ARCH_REG_NUM    8
`define PHY_REG_NUM     16
`define XLEN            16

// Queue depths
`define ROB_ENTRY_NUM   8
`define RS_ENTRY_NUM    4

// Issue edge to CDB, in cycles
`define ALU_LAT         2

// Index widths
`define ARCH_IDX_W      $clog2(`ARCH_REG_NUM)
`define PHY_IDX_W       $clog2(`PHY_REG_NUM)
`define ROB_IDX_W       $clog2(`ROB_ENTRY_NUM)

`endif

//--- rtl/ooo_pkg.sv
// Types passed between the dispatch, issue, execute and retire blocks
// Field widths come from ooo_defs.svh
`default_nettype none
`include "ooo_defs.svh"

package ooo_pkg;

    // ALU opcodes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LI  = 3'd5
    } alu_op_e;

    // In-order instruction from the front end
    typedef struct packed {
        alu_op_e                op;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`ARCH_IDX_W-1:0] rs1;
        logic [`ARCH_IDX_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
    } inst_t;

    // ------------------------------
    // Dispatch packets
    // ------------------------------
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [`XLEN-1:0]       imm;
        logic [`PHY_IDX_W-1:0]  src1_tag;
        logic [`PHY_IDX_W-1:0]  src2_tag;
        logic [`PHY_IDX_W-1:0]  dest_tag;
        logic [`ROB_IDX_W-1:0]  rob_idx;
    } dp_rs_t;

    typedef struct packed {
        logic                   valid;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`PHY_IDX_W-1:0]  dest_tag;
        logic [`PHY_IDX_W-1:0]  old_tag;   // previous mapping of rd
    } dp_rob_t;

    // ------------------------------
    // Execute and retire
    // ------------------------------
    typedef struct packed {
        logic                   valid;
        logic [`PHY_IDX_W-1:0]  tag;
        logic [`ROB_IDX_W-1:0]  rob_idx;
        logic [`XLEN-1:0]       value;
    } cdb_t;

    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [`XLEN-1:0]       imm;
        logic [`PHY_IDX_W-1:0]  src1_tag;
        logic [`PHY_IDX_W-1:0]  src2_tag;
        logic [`PHY_IDX_W-1:0]  dest_tag;
        logic [`ROB_IDX_W-1:0]  rob_idx;
    } rs_iss_t;

    typedef struct packed {
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`XLEN-1:0]       value;
        logic [`PHY_IDX_W-1:0]  free_tag;
    } retire_t;

    // ROB entry life cycle
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } dp_state_e;

endpackage

`default_nettype wire

//--- rtl/rename_table.sv
// Map table comes out of reset as identity, arch i on phys i
// Free list holds the remaining tags; no rollback, the map only moves forward
// Released tags are pushed one cycle after the retire pulse
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module rename_table (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [`ARCH_IDX_W-1:0] rd_arch1_i,
    input  logic [`ARCH_IDX_W-1:0] rd_arch2_i,
    input  logic [`ARCH_IDX_W-1:0] rd_arch_dst_i,
    input  logic                   alloc_i,
    input  logic                   free_valid_i,
    input  logic [`PHY_IDX_W-1:0]  free_tag_i,
    output logic [`PHY_IDX_W-1:0]  src1_tag_o,
    output logic [`PHY_IDX_W-1:0]  src2_tag_o,
    output logic [`PHY_IDX_W-1:0]  old_tag_o,
    output logic [`PHY_IDX_W-1:0]  new_tag_o,
    output logic                   fl_empty_o
);
    localparam int FL_NUM   = `PHY_REG_NUM - `ARCH_REG_NUM;
    localparam int FL_PTR_W = $clog2(FL_NUM);
    localparam int PHY_W    = `PHY_IDX_W;

    logic [`PHY_IDX_W-1:0] map_q [`ARCH_REG_NUM];
    logic [`PHY_IDX_W-1:0] fl_q [FL_NUM];
    logic [FL_PTR_W-1:0]   fl_head_q;
    logic [FL_PTR_W-1:0]   fl_tail_q;
    logic [FL_PTR_W:0]     fl_cnt_q;

    // Combinational lookups for dispatch
    assign src1_tag_o = map_q[rd_arch1_i];
    assign src2_tag_o = map_q[rd_arch2_i];
    assign old_tag_o  = map_q[rd_arch_dst_i];
    // Next free tag sits at the head
    assign new_tag_o  = fl_q[fl_head_q];
    assign fl_empty_o = (fl_cnt_q == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                map_q[i] <= PHY_W'(i);
            end
            // Tags above the architectural range start free
            for (int i = 0; i < FL_NUM; i++) begin
                fl_q[i] <= PHY_W'(`ARCH_REG_NUM + i);
            end
            fl_head_q <= '0;
            fl_tail_q <= '0;
            fl_cnt_q  <= FL_NUM[FL_PTR_W:0];
        end else begin
            // Rename rd and pop
            if (alloc_i) begin
                map_q[rd_arch_dst_i] <= fl_q[fl_head_q];
                fl_head_q            <= fl_head_q + 1'b1;
            end
            // Retired old mapping goes back
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_tag_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            case ({alloc_i, free_valid_i})
                2'b10:   fl_cnt_q <= fl_cnt_q - 1'b1;
                2'b01:   fl_cnt_q <= fl_cnt_q + 1'b1;
                default: fl_cnt_q <= fl_cnt_q;
            endcase
        end
    end

    // Dispatch must honor the empty flag
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_i |-> !fl_empty_o);

endmodule

`default_nettype wire

//--- rtl/dispatcher.sv
// Combinational dispatch; one instruction per cycle at most
// Stall is a level and does not depend on inst_valid_i
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module dispatcher (
    input  logic                  inst_valid_i,
    input  ooo_pkg::inst_t        inst_i,
    input  logic                  rob_full_i,
    input  logic                  rs_full_i,
    input  logic                  fl_empty_i,
    input  logic [`ROB_IDX_W-1:0] rob_tail_i,
    input  logic [`PHY_IDX_W-1:0] src1_tag_i,
    input  logic [`PHY_IDX_W-1:0] src2_tag_i,
    input  logic [`PHY_IDX_W-1:0] old_tag_i,
    input  logic [`PHY_IDX_W-1:0] new_tag_i,
    output logic                  stall_o,
    output logic                  alloc_o,
    output ooo_pkg::dp_rs_t       dp_rs_o,
    output ooo_pkg::dp_rob_t      dp_rob_o
);
    import ooo_pkg::*;

    logic is_li;

    // Any missing resource holds the front end
    assign stall_o = rob_full_i | rs_full_i | fl_empty_i;
    assign alloc_o = inst_valid_i & ~stall_o;
    assign is_li   = (inst_i.op == OP_LI);

    always_comb begin
        // RS entry, LI sources point at phys 0
        dp_rs_o.valid    = alloc_o;
        dp_rs_o.op       = inst_i.op;
        dp_rs_o.imm      = inst_i.imm;
        dp_rs_o.src1_tag = is_li ? '0 : src1_tag_i;
        dp_rs_o.src2_tag = is_li ? '0 : src2_tag_i;
        dp_rs_o.dest_tag = new_tag_i;
        dp_rs_o.rob_idx  = rob_tail_i;
        // ROB entry keeps the old tag for release
        dp_rob_o.valid    = alloc_o;
        dp_rob_o.rd       = inst_i.rd;
        dp_rob_o.dest_tag = new_tag_i;
        dp_rob_o.old_tag  = old_tag_i;
    end

endmodule

`default_nettype wire

//--- rtl/rsv_station.sv
// Four-entry RS with CDB wakeup; issues one entry per cycle
// Age among entries follows dispatch order, same as ROB order
// Issue is combinational from registered state, so no same-cycle issue
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module rsv_station (
    input  logic              clk_i,
    input  logic              reset_i,
    input  ooo_pkg::dp_rs_t   dp_rs_i,
    input  ooo_pkg::cdb_t     cdb_i,
    input  logic [1:0]        src_rdy_i,
    output logic              rs_full_o,
    output ooo_pkg::rs_iss_t  rs_iss_o
);
    import ooo_pkg::*;

    localparam int N     = `RS_ENTRY_NUM;
    localparam int IDX_W = $clog2(N);

    dp_rs_t           ent_q [N];
    logic [N-1:0]     valid_q;
    logic [N-1:0]     rdy1_q;
    logic [N-1:0]     rdy2_q;
    // ahead_q[i][j] set when entry j is older than entry i
    logic [N-1:0]     ahead_q [N];
    logic [N-1:0]     can_iss;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] iss_idx;
    logic             iss_hit;

    assign rs_full_o = &valid_q;
    assign can_iss   = valid_q & rdy1_q & rdy2_q;

    // Lowest free slot
    always_comb begin
        wr_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid_q[i]) wr_idx = IDX_W'(i);
        end
    end

    // Oldest ready entry, no older ready entry ahead of it
    always_comb begin
        iss_hit = 1'b0;
        iss_idx = '0;
        for (int i = 0; i < N; i++) begin
            if (can_iss[i] && ((can_iss & ahead_q[i]) == '0)) begin
                iss_hit = 1'b1;
                iss_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        rs_iss_o.valid    = iss_hit;
        rs_iss_o.op       = ent_q[iss_idx].op;
        rs_iss_o.imm      = ent_q[iss_idx].imm;
        rs_iss_o.src1_tag = ent_q[iss_idx].src1_tag;
        rs_iss_o.src2_tag = ent_q[iss_idx].src2_tag;
        rs_iss_o.dest_tag = ent_q[iss_idx].dest_tag;
        rs_iss_o.rob_idx  = ent_q[iss_idx].rob_idx;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (iss_hit) valid_q[iss_idx] <= 1'b0;
            if (dp_rs_i.valid) valid_q[wr_idx] <= 1'b1;
        end
    end

    // ------------------------------
    // Payload, wakeup and age
    // ------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < N; i++) begin
            if (cdb_i.valid && cdb_i.tag == ent_q[i].src1_tag) rdy1_q[i] <= 1'b1;
            if (cdb_i.valid && cdb_i.tag == ent_q[i].src2_tag) rdy2_q[i] <= 1'b1;
        end
        if (dp_rs_i.valid) begin
            ent_q[wr_idx]  <= dp_rs_i;
            // PRF ready bit, or a broadcast landing this cycle
            rdy1_q[wr_idx] <= src_rdy_i[0] | (cdb_i.valid && cdb_i.tag == dp_rs_i.src1_tag);
            rdy2_q[wr_idx] <= src_rdy_i[1] | (cdb_i.valid && cdb_i.tag == dp_rs_i.src2_tag);
            // New entry is younger than everything present
            for (int j = 0; j < N; j++) begin
                ahead_q[j][wr_idx] <= 1'b0;
            end
            ahead_q[wr_idx] <= valid_q;
        end
    end

    a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
        dp_rs_i.valid |-> !rs_full_o);

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
// Circular ROB, one dispatch and one retire per cycle
// Head retires on the edge after its CDB completion
// rt_o is valid only with the rt_valid_o pulse
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module reorder_buffer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  ooo_pkg::dp_rob_t      dp_rob_i,
    input  ooo_pkg::cdb_t         cdb_i,
    output logic                  rob_full_o,
    output logic [`ROB_IDX_W-1:0] rob_tail_o,
    output logic                  rt_valid_o,
    output ooo_pkg::retire_t      rt_o
);
    import ooo_pkg::*;

    localparam int N = `ROB_ENTRY_NUM;

    dp_state_e              state_q [N];
    logic [`ARCH_IDX_W-1:0] rd_q [N];
    logic [`PHY_IDX_W-1:0]  old_tag_q [N];
    logic [`XLEN-1:0]       value_q [N];
    logic [`ROB_IDX_W-1:0]  head_q;
    logic [`ROB_IDX_W-1:0]  tail_q;
    logic [`ROB_IDX_W:0]    cnt_q;
    logic                   retire;

    // Count MSB set means all N entries in use
    assign rob_full_o = cnt_q[`ROB_IDX_W];
    assign rob_tail_o = tail_q;
    assign retire     = (state_q[head_q] == DONE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < N; i++) begin
                state_q[i] <= IDLE;
            end
            head_q     <= '0;
            tail_q     <= '0;
            cnt_q      <= '0;
            rt_valid_o <= 1'b0;
        end else begin
            rt_valid_o <= retire;
            if (dp_rob_i.valid) begin
                state_q[tail_q] <= WAIT;
                tail_q          <= tail_q + 1'b1;
            end
            // Completion from the ALU
            if (cdb_i.valid) state_q[cdb_i.rob_idx] <= DONE;
            if (retire) begin
                state_q[head_q] <= IDLE;
                head_q          <= head_q + 1'b1;
            end
            case ({dp_rob_i.valid, retire})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // ------------------------------
    // Entry payload and retire record
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (dp_rob_i.valid) begin
            rd_q[tail_q]      <= dp_rob_i.rd;
            old_tag_q[tail_q] <= dp_rob_i.old_tag;
        end
        if (cdb_i.valid) value_q[cdb_i.rob_idx] <= cdb_i.value;
        if (retire) begin
            rt_o.rd       <= rd_q[head_q];
            rt_o.value    <= value_q[head_q];
            rt_o.free_tag <= old_tag_q[head_q];
        end
    end

    // Broadcast must land on an in-flight entry
    a_cdb_live: assert property (@(posedge clk_i) disable iff (reset_i)
        cdb_i.valid |-> state_q[cdb_i.rob_idx] == WAIT);

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
// PRF with a ready bit per register; all registers reset to 0 and ready
// Two read ports for issue, one write port from the CDB
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module phys_regfile (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  dp_clear_valid_i,
    input  logic [`PHY_IDX_W-1:0] dp_clear_tag_i,
    input  logic [`PHY_IDX_W-1:0] src1_tag_i,
    input  logic [`PHY_IDX_W-1:0] src2_tag_i,
    input  ooo_pkg::rs_iss_t      rs_iss_i,
    input  ooo_pkg::cdb_t         cdb_i,
    output logic [1:0]            src_rdy_o,
    output logic [`XLEN-1:0]      opnd1_o,
    output logic [`XLEN-1:0]      opnd2_o
);
    logic [`XLEN-1:0]        regs_q [`PHY_REG_NUM];
    logic [`PHY_REG_NUM-1:0] rdy_q;

    // Ready bits seed new RS entries
    assign src_rdy_o = {rdy_q[src2_tag_i], rdy_q[src1_tag_i]};
    // Operand read for the issuing entry
    assign opnd1_o   = regs_q[rs_iss_i.src1_tag];
    assign opnd2_o   = regs_q[rs_iss_i.src2_tag];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `PHY_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
            rdy_q <= '1;
        end else begin
            // New destination waits for its result
            if (dp_clear_valid_i) rdy_q[dp_clear_tag_i] <= 1'b0;
            if (cdb_i.valid) begin
                rdy_q[cdb_i.tag]  <= 1'b1;
                regs_q[cdb_i.tag] <= cdb_i.value;
            end
        end
    end

    // Result only goes to a register cleared at dispatch
    a_cdb_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        cdb_i.valid |-> !rdy_q[cdb_i.tag]);

endmodule

`default_nettype wire

//--- rtl/alu_pipe.sv
// Two-stage ALU, never stalls
// Result reaches the CDB ALU_LAT cycles after the issue edge
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module alu_pipe (
    input  logic              clk_i,
    input  logic              reset_i,
    input  ooo_pkg::rs_iss_t  rs_iss_i,
    input  logic [`XLEN-1:0]  opnd1_i,
    input  logic [`XLEN-1:0]  opnd2_i,
    output ooo_pkg::cdb_t     cdb_o
);
    import ooo_pkg::*;

    logic                  s1_valid_q;
    alu_op_e               s1_op_q;
    logic [`XLEN-1:0]      s1_a_q;
    logic [`XLEN-1:0]      s1_b_q;
    logic [`XLEN-1:0]      s1_imm_q;
    logic [`PHY_IDX_W-1:0] s1_tag_q;
    logic [`ROB_IDX_W-1:0] s1_rob_q;
    logic [`XLEN-1:0]      result;

    // Stage 2 compute
    always_comb begin
        case (s1_op_q)
            OP_ADD:  result = s1_a_q + s1_b_q;
            OP_SUB:  result = s1_a_q - s1_b_q;
            OP_AND:  result = s1_a_q & s1_b_q;
            OP_OR:   result = s1_a_q | s1_b_q;
            OP_XOR:  result = s1_a_q ^ s1_b_q;
            OP_LI:   result = s1_imm_q;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        // Stage 1 captures the issued entry
        s1_op_q       <= rs_iss_i.op;
        s1_a_q        <= opnd1_i;
        s1_b_q        <= opnd2_i;
        s1_imm_q      <= rs_iss_i.imm;
        s1_tag_q      <= rs_iss_i.dest_tag;
        s1_rob_q      <= rs_iss_i.rob_idx;
        // Stage 2 drives the bus
        cdb_o.tag     <= s1_tag_q;
        cdb_o.rob_idx <= s1_rob_q;
        cdb_o.value   <= result;
        if (reset_i) begin
            s1_valid_q  <= 1'b0;
            cdb_o.valid <= 1'b0;
        end else begin
            s1_valid_q  <= rs_iss_i.valid;
            cdb_o.valid <= s1_valid_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pipeline_dp.sv
// Dispatch slice top: rename, RS, ROB, PRF and one ALU on a single CDB
// Front end holds inst_i and inst_valid_i while dp_stall_o is high
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module pipeline_dp (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              inst_valid_i,
    input  ooo_pkg::inst_t    inst_i,
    output logic              dp_stall_o,
    output logic              rt_valid_o,
    output ooo_pkg::retire_t  rt_o
);
    import ooo_pkg::*;

    // Rename paths
    logic [`PHY_IDX_W-1:0] src1_tag;
    logic [`PHY_IDX_W-1:0] src2_tag;
    logic [`PHY_IDX_W-1:0] old_tag;
    logic [`PHY_IDX_W-1:0] new_tag;
    logic                  alloc;
    logic                  fl_empty;
    // Queue status and packets
    logic                  rob_full;
    logic                  rs_full;
    logic [`ROB_IDX_W-1:0] rob_tail;
    dp_rs_t                dp_rs;
    dp_rob_t               dp_rob;
    rs_iss_t               rs_iss;
    cdb_t                  cdb;
    logic [1:0]            src_rdy;
    logic [`XLEN-1:0]      opnd1;
    logic [`XLEN-1:0]      opnd2;

    dispatcher i_dispatcher (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rob_full_i   (rob_full),
        .rs_full_i    (rs_full),
        .fl_empty_i   (fl_empty),
        .rob_tail_i   (rob_tail),
        .src1_tag_i   (src1_tag),
        .src2_tag_i   (src2_tag),
        .old_tag_i    (old_tag),
        .new_tag_i    (new_tag),
        .stall_o      (dp_stall_o),
        .alloc_o      (alloc),
        .dp_rs_o      (dp_rs),
        .dp_rob_o     (dp_rob)
    );

    // Retired old tags feed the free list
    rename_table i_rename (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rd_arch1_i    (inst_i.rs1),
        .rd_arch2_i    (inst_i.rs2),
        .rd_arch_dst_i (inst_i.rd),
        .alloc_i       (alloc),
        .free_valid_i  (rt_valid_o),
        .free_tag_i    (rt_o.free_tag),
        .src1_tag_o    (src1_tag),
        .src2_tag_o    (src2_tag),
        .old_tag_o     (old_tag),
        .new_tag_o     (new_tag),
        .fl_empty_o    (fl_empty)
    );

    rsv_station i_rs (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .dp_rs_i   (dp_rs),
        .cdb_i     (cdb),
        .src_rdy_i (src_rdy),
        .rs_full_o (rs_full),
        .rs_iss_o  (rs_iss)
    );

    reorder_buffer i_rob (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .dp_rob_i   (dp_rob),
        .cdb_i      (cdb),
        .rob_full_o (rob_full),
        .rob_tail_o (rob_tail),
        .rt_valid_o (rt_valid_o),
        .rt_o       (rt_o)
    );

    // Ready lookup uses the LI-adjusted source tags
    phys_regfile i_prf (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dp_clear_valid_i (dp_rob.valid),
        .dp_clear_tag_i   (dp_rob.dest_tag),
        .src1_tag_i       (dp_rs.src1_tag),
        .src2_tag_i       (dp_rs.src2_tag),
        .rs_iss_i         (rs_iss),
        .cdb_i            (cdb),
        .src_rdy_o        (src_rdy),
        .opnd1_o          (opnd1),
        .opnd2_o          (opnd2)
    );

    alu_pipe i_alu (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .rs_iss_i (rs_iss),
        .opnd1_i  (opnd1),
        .opnd2_i  (opnd2),
        .cdb_o    (cdb)
    );

endmodule

`default_nettype wire

//--- bench/tb_pipeline_dp.sv
// Trace-driven bench for pipeline_dp; run from the project root so the trace path resolves
// Expected retirements come from the trace and are cross-checked by an architectural model
// Inputs change 2 ns after the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none
`include "ooo_defs.svh"

module tb_pipeline_dp;
    import ooo_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;

    logic    clk_i;
    logic    reset_i;
    logic    inst_valid_i;
    inst_t   inst_i;
    logic    dp_stall_o;
    logic    rt_valid_o;
    retire_t rt_o;

    // Trace contents in program order
    inst_t   prog_q[$];
    int      idle_q[$];
    retire_t exp_q[$];
    logic    loaded;

    int      value_errs   = 0;
    int      other_errs   = 0;
    int      n_dispatched = 0;
    int      n_retired    = 0;
    int      stall_cycles = 0;

    pipeline_dp i_dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .dp_stall_o   (dp_stall_o),
        .rt_valid_o   (rt_valid_o),
        .rt_o         (rt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // Trace and reference model
    // ------------------------------
    function automatic bit decode_op(input string name, output alu_op_e op);
        op = OP_ADD;
        case (name)
            "ADD":   op = OP_ADD;
            "SUB":   op = OP_SUB;
            "AND":   op = OP_AND;
            "OR":    op = OP_OR;
            "XOR":   op = OP_XOR;
            "LI":    op = OP_LI;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // Architectural result of one instruction
    function automatic logic [`XLEN-1:0] model_result(inst_t ins, logic [`XLEN-1:0] a,
                                                      logic [`XLEN-1:0] b);
        case (ins.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_LI:   return ins.imm;
            default: return '0;
        endcase
    endfunction

    task automatic load_trace();
        int                     fd;
        int                     code;
        int                     idle;
        string                  tok;
        string                  name;
        string                  rest;
        alu_op_e                op;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`ARCH_IDX_W-1:0] rs1;
        logic [`ARCH_IDX_W-1:0] rs2;
        logic [`XLEN-1:0]       val;
        inst_t                  ins;
        retire_t                rt;
        fd = $fopen("bench/dp_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file bench/dp_trace.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) break;
            if (tok == "I") begin
                code = $fscanf(fd, " %d %s %d %d %d %h", idle, name, rd, rs1, rs2, val);
                if (code != 6 || !decode_op(name, op)) begin
                    $display("Malformed instruction line in the trace near %s", name);
                    other_errs++;
                end else begin
                    ins = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: val};
                    prog_q.push_back(ins);
                    idle_q.push_back(idle);
                end
            end else if (tok == "R") begin
                code = $fscanf(fd, " %d %h", rd, val);
                rt   = '{rd: rd, value: val, free_tag: '0};
                exp_q.push_back(rt);
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else begin
                $display("Unknown record %s in the trace", tok);
                other_errs++;
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    // Trace retirements must agree with the architectural model
    // Released tags follow from the identity map and a FIFO free list of 8 to 15
    task automatic check_trace();
        logic [`XLEN-1:0]      arch [`ARCH_REG_NUM];
        logic [`XLEN-1:0]      res;
        logic [`PHY_IDX_W-1:0] map_tag [`ARCH_REG_NUM];
        logic [`PHY_IDX_W-1:0] free_seq [$];
        logic [`PHY_IDX_W-1:0] new_tag;
        retire_t               rt;
        for (int i = 0; i < `ARCH_REG_NUM; i++) begin
            arch[i]    = '0;
            map_tag[i] = i[`PHY_IDX_W-1:0];
        end
        for (int i = `ARCH_REG_NUM; i < `PHY_REG_NUM; i++) begin
            free_seq.push_back(i[`PHY_IDX_W-1:0]);
        end
        if (exp_q.size() != prog_q.size() || prog_q.size() == 0) begin
            $display("Trace lists %0d instructions but %0d retirements",
                     prog_q.size(), exp_q.size());
            other_errs++;
        end
        foreach (prog_q[k]) begin
            res = model_result(prog_q[k], arch[prog_q[k].rs1], arch[prog_q[k].rs2]);
            arch[prog_q[k].rd] = res;
            if (k < exp_q.size()) begin
                if (exp_q[k].rd != prog_q[k].rd || exp_q[k].value != res) begin
                    $display("Trace retirement %0d disagrees with the model value %h", k, res);
                    other_errs++;
                end
                // Old mapping of rd comes back at retire
                rt          = exp_q[k];
                rt.free_tag = map_tag[prog_q[k].rd];
                exp_q[k]    = rt;
            end
            // Released tags rejoin the list in program order
            new_tag = free_seq.pop_front();
            free_seq.push_back(map_tag[prog_q[k].rd]);
            map_tag[prog_q[k].rd] = new_tag;
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_retire(input retire_t got, input retire_t exp, input int idx);
        if (got.rd !== exp.rd || got.value !== exp.value) begin
            $display("ERROR %0t: retire %0d got rd %0d value %h, expected rd %0d value %h",
                     $time, idx, got.rd, got.value, exp.rd, exp.value);
            value_errs++;
        end
        // Released tag is the previous mapping of rd
        if (got.free_tag !== exp.free_tag) begin
            $display("ERROR %0t: retire %0d free_tag %0d, expected %0d",
                     $time, idx, got.free_tag, exp.free_tag);
            value_errs++;
        end
    endtask

    task automatic check_stall(input logic exp);
        if (dp_stall_o !== exp) begin
            $display("ERROR %0t: dp_stall_o is %b, expected %b", $time, dp_stall_o, exp);
            value_errs++;
        end
    endtask

    task automatic check_no_retire();
        if (rt_valid_o !== 1'b0) begin
            $display("ERROR %0t: rt_valid_o is %b during the idle lead-in", $time, rt_valid_o);
            value_errs++;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic drive_program();
        logic accepted;
        foreach (prog_q[k]) begin
            inst_valid_i = 1'b0;
            repeat (idle_q[k]) begin
                @(negedge clk_i);
                // Nothing in flight before the first instruction
                if (k == 0) begin
                    check_stall(1'b0);
                    check_no_retire();
                end
                @(posedge clk_i);
                #(DRIVE_DLY);
            end
            inst_valid_i = 1'b1;
            inst_i       = prog_q[k];
            accepted     = 1'b0;
            // Hold the instruction while stalled
            while (!accepted) begin
                @(negedge clk_i);
                if (dp_stall_o === 1'b0) accepted = 1'b1;
                else stall_cycles++;
                @(posedge clk_i);
                #(DRIVE_DLY);
            end
            n_dispatched++;
        end
        inst_valid_i = 1'b0;
        inst_i       = '0;
    endtask

    task automatic print_summary();
        $display("Errors: %0d value, %0d other; dispatched %0d, retired %0d, stall cycles %0d",
                 value_errs, other_errs, n_dispatched, n_retired, stall_cycles);
    endtask

    // Retirements in program order
    initial begin : retire_monitor
        forever begin
            @(negedge clk_i);
            if (reset_i === 1'b0 && rt_valid_o === 1'b1) begin
                if (n_retired < exp_q.size()) begin
                    check_retire(rt_o, exp_q[n_retired], n_retired);
                end else begin
                    $display("Retirement %0d has no entry in the trace", n_retired);
                    other_errs++;
                end
                n_retired++;
            end
        end
    end

    initial begin : watchdog
        wait (loaded === 1'b1);
        repeat (prog_q.size() * 20 + 200) @(posedge clk_i);
        $display("Run timed out with %0d of %0d instructions retired",
                 n_retired, prog_q.size());
        print_summary();
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        loaded       = 1'b0;
        load_trace();
        check_trace();
        loaded = 1'b1;
        repeat (2) @(posedge clk_i);
        #(DRIVE_DLY);
        reset_i = 1'b0;
        if (prog_q.size() > 0) begin
            drive_program();
            wait (n_retired >= prog_q.size());
            // Window for stray retirements
            repeat (10) @(posedge clk_i);
        end
        if (n_retired != n_dispatched || n_dispatched != prog_q.size()) begin
            $display("Retired %0d instructions after dispatching %0d", n_retired, n_dispatched);
            other_errs++;
        end
        if (stall_cycles == 0) begin
            $display("dp_stall_o never rose, so the burst did not fill the ROB or RS");
            other_errs++;
        end
        print_summary();
        if (value_errs + other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/dp_trace.txt
# I idle op rd rs1 rs2 imm(hex): instruction after <idle> empty cycles
# R rd value(hex): expected retirements in program order
I 4 LI  1 0 0 0005
I 0 LI  2 0 0 0003
I 0 ADD 3 1 2 0000
I 2 SUB 4 3 1 0000
I 0 XOR 5 4 3 0000
I 0 ADD 1 5 2 0000
I 0 LI  1 0 0 1234
I 1 OR  6 1 3 0000
I 0 AND 7 6 5 0000
I 3 SUB 0 2 7 0000
I 0 LI  2 0 0 00ff
I 0 ADD 2 2 2 0000
I 0 ADD 3 2 2 0000
I 0 XOR 2 3 2 0000
I 0 SUB 4 2 0 0000
I 0 OR  5 4 1 0000
I 0 AND 6 5 3 0000
I 0 ADD 7 6 6 0000
I 0 XOR 1 7 1 0000
I 0 SUB 0 1 7 0000
R 1 0005
R 2 0003
R 3 0008
R 4 0003
R 5 000b
R 1 000e
R 1 1234
R 6 123c
R 7 0008
R 0 fffb
R 2 00ff
R 2 01fe
R 3 03fc
R 2 0202
R 4 0207
R 5 1237
R 6 0234
R 7 0468
R 1 165c
R 0 11f4

//--- build.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/rename_table.sv
rtl/dispatcher.sv
rtl/rsv_station.sv
rtl/reorder_buffer.sv
rtl/phys_regfile.sv
rtl/alu_pipe.sv
rtl/pipeline_dp.sv
bench/tb_pipeline_dp.sv

//--- Makefile
# Verilator simulation of pipeline_dp, run from the project root

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f build.f --top-module tb_pipeline_dp -Mdir obj_dir
	./obj_dir/Vtb_pipeline_dp 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
